// ==== wr_config.svh ====
// Weight rotator sizing
// Word width and the largest kernel and image dimensions that the banks hold

`ifndef WR_CONFIG_SVH
`define WR_CONFIG_SVH

// ==================================================
// Stream word
// ==================================================
`define WR_WORD_W      32

// ==================================================
// Largest header field values
// ==================================================
`define WR_KH_MAX      3
`define WR_CIN_MAX     8
`define WR_COLS_MAX    4
`define WR_BLOCKS_MAX  4

// One bank holds a full kh x cin weight set
`define WR_DEPTH       (`WR_KH_MAX * `WR_CIN_MAX)

`endif

// ==== wr_pkg.sv ====
// Weight rotator types
// Header field, bank address and header record types built from the sizing macros

`include "wr_config.svh"

package wr_pkg;

  localparam int KH_W     = $clog2(`WR_KH_MAX);
  localparam int CIN_W    = $clog2(`WR_CIN_MAX);
  localparam int COLS_W   = $clog2(`WR_COLS_MAX);
  localparam int BLOCKS_W = $clog2(`WR_BLOCKS_MAX);
  localparam int ADDR_W   = $clog2(`WR_DEPTH);

  typedef logic [`WR_WORD_W-1:0] word_t;

  // Minus-one header fields
  typedef logic [KH_W-1:0]     kh_t;
  typedef logic [CIN_W-1:0]    cin_t;
  typedef logic [COLS_W-1:0]   cols_t;
  typedef logic [BLOCKS_W-1:0] blocks_t;

  typedef logic [ADDR_W-1:0]   addr_t;

  // Low bits of the header beat with kh_1 at bit 0
  typedef struct packed {
    blocks_t blocks_1;
    cols_t   cols_1;
    cin_t    cin_1;
    kh_t     kh_1;
  } hdr_t;

endpackage

// ==== wr_loader.sv ====
// Weight rotator loader
// Takes one header beat and the weight beats that follow it, writes them
// into the free bank and commits the bank on the last weight

module wr_loader (
  input  logic          aclk,
  input  logic          i_rst_n,
  input  logic          i_s_valid,
  input  wr_pkg::word_t i_s_data,
  output logic          o_s_ready,
  input  logic          i_wr_free,
  output logic          o_hdr_load,
  output wr_pkg::hdr_t  o_hdr,
  output logic          o_wr_en,
  output wr_pkg::addr_t o_wr_addr,
  output wr_pkg::word_t o_wr_data,
  output logic          o_commit
);

  import wr_pkg::*;

  typedef enum logic [1:0] {L_IDLE, L_HDR, L_WGT} state_t;

  state_t state;
  hdr_t   s_hdr;
  addr_t  wr_addr;
  addr_t  wr_last;
  logic   s_hs;

  // Header fields come straight off the low bits of the beat
  assign s_hdr = hdr_t'(i_s_data[$bits(hdr_t)-1:0]);

  assign o_s_ready  = (state != L_IDLE);
  assign s_hs       = i_s_valid && o_s_ready;

  assign o_hdr      = s_hdr;
  assign o_hdr_load = s_hs && (state == L_HDR);

  assign o_wr_en    = s_hs && (state == L_WGT);
  assign o_wr_addr  = wr_addr;
  assign o_wr_data  = i_s_data;
  assign o_commit   = o_wr_en && (wr_addr == wr_last);

  // ==================================================
  // Load FSM
  // ==================================================
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      state   <= L_IDLE;
      wr_addr <= '0;
    end else begin
      case (state)
        L_IDLE: if (i_wr_free) state <= L_HDR;
        L_HDR: begin
          if (s_hs) begin
            state   <= L_WGT;
            wr_addr <= '0;
          end
        end
        L_WGT: begin
          if (o_commit) state <= L_IDLE;
          else if (o_wr_en) wr_addr <= wr_addr + 1'b1;
        end
        default: state <= L_IDLE;
      endcase
    end
  end

  // Last address of the weight set is (kh_1+1)*(cin_1+1)-1 multiplied out
  always_ff @(posedge aclk) begin
    if (o_hdr_load) begin
      wr_last <= addr_t'(s_hdr.kh_1) * addr_t'(s_hdr.cin_1)
               + addr_t'(s_hdr.kh_1) + addr_t'(s_hdr.cin_1);
    end
  end

endmodule

// ==== wr_bank_pair.sv ====
// Weight rotator bank pair
// Two weight memories with header registers and full flags. Writes go to the
// bank under the write pointer, reads come from the bank under the read pointer

`include "wr_config.svh"

module wr_bank_pair (
  input  logic          aclk,
  input  logic          i_rst_n,
  input  logic          i_hdr_load,
  input  wr_pkg::hdr_t  i_hdr,
  input  logic          i_wr_en,
  input  wr_pkg::addr_t i_wr_addr,
  input  wr_pkg::word_t i_wr_data,
  input  logic          i_commit,
  output logic          o_wr_free,
  input  wr_pkg::addr_t i_rd_addr,
  input  logic          i_release,
  output logic          o_rd_ready,
  output wr_pkg::hdr_t  o_rd_hdr,
  output wr_pkg::word_t o_rd_data
);

  import wr_pkg::*;

  word_t      mem [2][`WR_DEPTH];
  hdr_t       hdr_q [2];
  logic [1:0] full;
  logic       wr_ptr;
  logic       rd_ptr;

  // A bank is free to write only once the reader has let go of it
  assign o_wr_free  = !full[wr_ptr];
  assign o_rd_ready = full[rd_ptr];

  // Asynchronous read keeps the output word valid without a prefetch
  assign o_rd_hdr   = hdr_q[rd_ptr];
  assign o_rd_data  = mem[rd_ptr][i_rd_addr];

  // ==================================================
  // Storage
  // ==================================================
  always_ff @(posedge aclk) begin
    if (i_wr_en) mem[wr_ptr][i_wr_addr] <= i_wr_data;
    if (i_hdr_load) hdr_q[wr_ptr] <= i_hdr;
  end

  // ==================================================
  // Full flags and bank pointers
  // ==================================================
  // Commit and release never hit the same bank in one cycle
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      full   <= '0;
      wr_ptr <= 1'b0;
      rd_ptr <= 1'b0;
    end else begin
      if (i_commit) begin
        full[wr_ptr] <= 1'b1;
        wr_ptr       <= ~wr_ptr;
      end
      if (i_release) begin
        full[rd_ptr] <= 1'b0;
        rd_ptr       <= ~rd_ptr;
      end
    end
  end

endmodule

// ==== wr_reader.sv ====
// Weight rotator reader
// Replays the full bank (cols_1+1)*(blocks_1+1) times with nested down-counters,
// drives the output flags and releases the bank on the final beat

module wr_reader (
  input  logic          aclk,
  input  logic          i_rst_n,
  input  logic          i_rd_ready,
  input  wr_pkg::hdr_t  i_rd_hdr,
  output wr_pkg::addr_t o_rd_addr,
  output logic          o_release,
  input  logic          i_m_ready,
  output logic          o_m_valid,
  output logic          o_m_cin_last,
  output logic          o_m_top_block,
  output logic          o_m_bottom_block,
  output logic          o_m_last
);

  import wr_pkg::*;

  typedef enum logic {R_IDLE, R_READ} state_t;

  state_t  state;
  kh_t     cnt_kh;
  cin_t    cnt_cin;
  cols_t   cnt_cols;
  blocks_t cnt_blocks;
  addr_t   rd_addr;

  logic last_kh;
  logic last_cin;
  logic last_cols;
  logic last_blocks;
  logic m_hs;

  assign last_kh     = (cnt_kh == '0);
  assign last_cin    = (cnt_cin == '0);
  assign last_cols   = (cnt_cols == '0);
  assign last_blocks = (cnt_blocks == '0);

  assign o_m_valid = (state == R_READ);
  assign m_hs      = o_m_valid && i_m_ready;
  assign o_rd_addr = rd_addr;

  // ==================================================
  // Output flags
  // ==================================================
  // Blocks count down, so the top block is the one still at its reload value
  assign o_m_cin_last     = last_kh && last_cin;
  assign o_m_top_block    = (cnt_blocks == i_rd_hdr.blocks_1);
  assign o_m_bottom_block = last_blocks;
  assign o_m_last         = o_m_cin_last && last_cols && last_blocks;
  assign o_release        = m_hs && o_m_last;

  // ==================================================
  // Read FSM and nested counters
  // ==================================================
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      state      <= R_IDLE;
      cnt_kh     <= '0;
      cnt_cin    <= '0;
      cnt_cols   <= '0;
      cnt_blocks <= '0;
      rd_addr    <= '0;
    end else begin
      case (state)
        R_IDLE: begin
          if (i_rd_ready) begin
            state      <= R_READ;
            cnt_kh     <= i_rd_hdr.kh_1;
            cnt_cin    <= i_rd_hdr.cin_1;
            cnt_cols   <= i_rd_hdr.cols_1;
            cnt_blocks <= i_rd_hdr.blocks_1;
            rd_addr    <= '0;
          end
        end
        R_READ: begin
          if (m_hs) begin
            cnt_kh <= last_kh ? i_rd_hdr.kh_1 : cnt_kh - 1'b1;
            if (last_kh) cnt_cin <= last_cin ? i_rd_hdr.cin_1 : cnt_cin - 1'b1;
            if (o_m_cin_last) begin
              cnt_cols <= last_cols ? i_rd_hdr.cols_1 : cnt_cols - 1'b1;
            end
            if (o_m_cin_last && last_cols) begin
              cnt_blocks <= last_blocks ? i_rd_hdr.blocks_1 : cnt_blocks - 1'b1;
            end
            // Wrap back to word 0 at the end of each repetition
            rd_addr <= o_m_cin_last ? '0 : rd_addr + 1'b1;
            if (o_m_last) state <= R_IDLE;
          end
        end
      endcase
    end
  end

endmodule

// ==== weight_rotator.sv ====
// Double-buffered convolution weight rotator
// Loads a weight set into one bank while the other bank is replayed on the output

module weight_rotator (
  input  logic          aclk,
  input  logic          i_rst_n,
  input  logic          i_s_valid,
  input  wr_pkg::word_t i_s_data,
  output logic          o_s_ready,
  input  logic          i_m_ready,
  output logic          o_m_valid,
  output wr_pkg::word_t o_m_data,
  output logic          o_m_cin_last,
  output logic          o_m_top_block,
  output logic          o_m_bottom_block,
  output logic          o_m_last
);

  import wr_pkg::*;

  // Loader to banks
  logic  hdr_load;
  hdr_t  wr_hdr;
  logic  wr_en;
  addr_t wr_addr;
  word_t wr_data;
  logic  commit;
  logic  wr_free;

  // Banks to reader
  logic  rd_ready;
  hdr_t  rd_hdr;
  addr_t rd_addr;
  logic  rd_release;

  wr_loader u_loader (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_s_valid  (i_s_valid),
    .i_s_data   (i_s_data),
    .o_s_ready  (o_s_ready),
    .i_wr_free  (wr_free),
    .o_hdr_load (hdr_load),
    .o_hdr      (wr_hdr),
    .o_wr_en    (wr_en),
    .o_wr_addr  (wr_addr),
    .o_wr_data  (wr_data),
    .o_commit   (commit)
  );

  wr_bank_pair u_banks (
    .aclk       (aclk),
    .i_rst_n    (i_rst_n),
    .i_hdr_load (hdr_load),
    .i_hdr      (wr_hdr),
    .i_wr_en    (wr_en),
    .i_wr_addr  (wr_addr),
    .i_wr_data  (wr_data),
    .i_commit   (commit),
    .o_wr_free  (wr_free),
    .i_rd_addr  (rd_addr),
    .i_release  (rd_release),
    .o_rd_ready (rd_ready),
    .o_rd_hdr   (rd_hdr),
    .o_rd_data  (o_m_data)
  );

  wr_reader u_reader (
    .aclk             (aclk),
    .i_rst_n          (i_rst_n),
    .i_rd_ready       (rd_ready),
    .i_rd_hdr         (rd_hdr),
    .o_rd_addr        (rd_addr),
    .o_release        (rd_release),
    .i_m_ready        (i_m_ready),
    .o_m_valid        (o_m_valid),
    .o_m_cin_last     (o_m_cin_last),
    .o_m_top_block    (o_m_top_block),
    .o_m_bottom_block (o_m_bottom_block),
    .o_m_last         (o_m_last)
  );

endmodule

// ==== weight_rotator_asserts.sv ====
// Weight rotator checker
// Rebuilds each packet from the input handshakes and checks the replayed
// output stream, its flags and the bank handshake rules against it

`include "wr_config.svh"

module weight_rotator_asserts (
  input logic          aclk,
  input logic          i_rst_n,
  input logic          i_s_valid,
  input wr_pkg::word_t i_s_data,
  input logic          o_s_ready,
  input logic          i_m_ready,
  input logic          o_m_valid,
  input wr_pkg::word_t o_m_data,
  input logic          o_m_cin_last,
  input logic          o_m_top_block,
  input logic          o_m_bottom_block,
  input logic          o_m_last
);

  import wr_pkg::*;

  localparam int SLOTS = 4;

  word_t      mdl_mem [SLOTS][`WR_DEPTH];
  int         mdl_words [SLOTS];
  int         mdl_reps [SLOTS];
  int         mdl_blocks [SLOTS];
  logic [1:0] in_slot;
  logic [1:0] out_slot;
  logic       in_hdr_phase;
  int         in_cnt;
  int         out_beat;
  int         pending;

  int    fail_cnt = 0;
  string fail_msg;

  hdr_t  in_hdr;
  logic  in_hs;
  logic  in_commit;
  logic  out_hs;
  word_t exp_data;
  logic  exp_cin_last;
  logic  exp_top;
  logic  exp_bottom;
  logic  exp_last;

  assign in_hdr    = hdr_t'(i_s_data[$bits(hdr_t)-1:0]);
  assign in_hs     = i_s_valid && o_s_ready;
  assign in_commit = in_hs && !in_hdr_phase && (in_cnt == mdl_words[in_slot] - 1);
  assign out_hs    = o_m_valid && i_m_ready;

  // Position in the packet being replayed
  always_comb begin
    int pos;
    int rep;
    int blk;
    pos          = out_beat % mdl_words[out_slot];
    rep          = out_beat / mdl_words[out_slot];
    blk          = rep / mdl_reps[out_slot];
    exp_data     = mdl_mem[out_slot][pos];
    exp_cin_last = (pos == mdl_words[out_slot] - 1);
    exp_top      = (blk == 0);
    exp_bottom   = (blk == mdl_blocks[out_slot] - 1);
    exp_last     = (out_beat == mdl_words[out_slot] * mdl_reps[out_slot]
                                * mdl_blocks[out_slot] - 1);
  end

  // ==================================================
  // Packet model
  // ==================================================
  always_ff @(posedge aclk) begin
    if (!i_rst_n) begin
      in_slot      <= '0;
      out_slot     <= '0;
      in_hdr_phase <= 1'b1;
      in_cnt       <= 0;
      out_beat     <= 0;
      pending      <= 0;
      for (int i = 0; i < SLOTS; i++) begin
        mdl_words[i]  <= 1;
        mdl_reps[i]   <= 1;
        mdl_blocks[i] <= 1;
      end
    end else begin
      if (in_hs && in_hdr_phase) begin
        mdl_words[in_slot]  <= (int'(in_hdr.kh_1) + 1) * (int'(in_hdr.cin_1) + 1);
        mdl_reps[in_slot]   <= int'(in_hdr.cols_1) + 1;
        mdl_blocks[in_slot] <= int'(in_hdr.blocks_1) + 1;
        in_hdr_phase        <= 1'b0;
        in_cnt              <= 0;
      end else if (in_hs) begin
        mdl_mem[in_slot][in_cnt] <= i_s_data;
        in_cnt                   <= in_cnt + 1;
        if (in_commit) begin
          in_slot      <= in_slot + 1'b1;
          in_hdr_phase <= 1'b1;
        end
      end
      if (out_hs) begin
        out_beat <= exp_last ? 0 : out_beat + 1;
        if (exp_last) out_slot <= out_slot + 1'b1;
      end
      pending <= pending + int'(in_commit) - int'(out_hs && exp_last);
    end
  end

  function automatic void record_failure(input string msg);
    fail_msg = msg;
    fail_cnt = fail_cnt + 1;
    $error("%s", msg);
  endfunction

  // ==================================================
  // Assertions
  // ==================================================
  a_reset_quiet: assert property (@(posedge aclk)
    !i_rst_n |=> !o_s_ready && !o_m_valid)
    else record_failure("ready or valid high right after reset");

  a_no_early_valid: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (pending == 0) |-> !o_m_valid)
    else record_failure("output valid with no complete packet stored");

  a_data: assert property (@(posedge aclk) disable iff (!i_rst_n)
    out_hs |-> (pending != 0) && (o_m_data == exp_data))
    else record_failure("output word differs from the stored weight");

  a_flags: assert property (@(posedge aclk) disable iff (!i_rst_n)
    out_hs |-> (o_m_cin_last == exp_cin_last) && (o_m_top_block == exp_top)
               && (o_m_bottom_block == exp_bottom))
    else record_failure("cin_last, top_block or bottom_block flag is wrong");

  a_last: assert property (@(posedge aclk) disable iff (!i_rst_n)
    out_hs |-> (o_m_last == exp_last))
    else record_failure("last flag is not on the final beat of the packet");

  a_hold: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (o_m_valid && !i_m_ready) |=> o_m_valid
      && $stable({o_m_data, o_m_cin_last, o_m_top_block, o_m_bottom_block, o_m_last}))
    else record_failure("output changed while stalled");

  a_valid_rises: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (pending != 0 && !o_m_valid) |-> ##[1:2] o_m_valid)
    else record_failure("output valid did not rise for a full bank");

  a_accept_free: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (pending < 2 && in_hdr_phase && !o_s_ready) |-> ##[1:2] o_s_ready)
    else record_failure("input not ready although a bank is free");

  a_no_third: assert property (@(posedge aclk) disable iff (!i_rst_n)
    (in_hs && in_hdr_phase) |-> (pending < 2))
    else record_failure("header accepted while both banks are full");

endmodule

bind weight_rotator weight_rotator_asserts u_asserts (
  .aclk             (aclk),
  .i_rst_n          (i_rst_n),
  .i_s_valid        (i_s_valid),
  .i_s_data         (i_s_data),
  .o_s_ready        (o_s_ready),
  .i_m_ready        (i_m_ready),
  .o_m_valid        (o_m_valid),
  .o_m_data         (o_m_data),
  .o_m_cin_last     (o_m_cin_last),
  .o_m_top_block    (o_m_top_block),
  .o_m_bottom_block (o_m_bottom_block),
  .o_m_last         (o_m_last)
);

// ==== tb_weight_rotator.sv ====
// Weight rotator testbench
// Random packets with random input and output stalls, checked by the bound
// assertion module

`include "wr_config.svh"

module tb_weight_rotator;

  import wr_pkg::*;

  localparam int NUM_PKTS     = 12;
  localparam int STALL_CYCLES = 20;

  logic  aclk;
  logic  i_rst_n;
  logic  i_s_valid;
  word_t i_s_data;
  logic  o_s_ready;
  logic  i_m_ready;
  logic  o_m_valid;
  word_t o_m_data;
  logic  o_m_cin_last;
  logic  o_m_top_block;
  logic  o_m_bottom_block;
  logic  o_m_last;

  word_t       in_beats [$];
  int          pkt_end [NUM_PKTS];
  logic [31:0] rng_src;
  logic [31:0] rng_snk;
  int          pkts_in;
  int          pkts_out;
  longint      wd_limit;

  weight_rotator UUT (
    .aclk             (aclk),
    .i_rst_n          (i_rst_n),
    .i_s_valid        (i_s_valid),
    .i_s_data         (i_s_data),
    .o_s_ready        (o_s_ready),
    .i_m_ready        (i_m_ready),
    .o_m_valid        (o_m_valid),
    .o_m_data         (o_m_data),
    .o_m_cin_last     (o_m_cin_last),
    .o_m_top_block    (o_m_top_block),
    .o_m_bottom_block (o_m_bottom_block),
    .o_m_last         (o_m_last)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // ==================================================
  // Packet generation
  // ==================================================
  // Total counts input beats plus replayed output beats
  task automatic build_packets(output int total);
    hdr_t  hdr;
    word_t beat;
    int    words;
    total = 0;
    for (int p = 0; p < NUM_PKTS; p++) begin
      rng_src      = xorshift32(rng_src);
      hdr.kh_1     = kh_t'(rng_src % `WR_KH_MAX);
      hdr.cin_1    = cin_t'((rng_src >> 8) % `WR_CIN_MAX);
      hdr.cols_1   = cols_t'((rng_src >> 16) % `WR_COLS_MAX);
      hdr.blocks_1 = blocks_t'((rng_src >> 24) % `WR_BLOCKS_MAX);
      rng_src      = xorshift32(rng_src);
      beat         = rng_src;
      beat[$bits(hdr_t)-1:0] = hdr;
      in_beats.push_back(beat);
      words = (int'(hdr.kh_1) + 1) * (int'(hdr.cin_1) + 1);
      for (int w = 0; w < words; w++) begin
        rng_src = xorshift32(rng_src);
        in_beats.push_back(rng_src);
      end
      pkt_end[p] = in_beats.size() - 1;
      total += 1 + words + words * (int'(hdr.cols_1) + 1) * (int'(hdr.blocks_1) + 1);
    end
  endtask

  task automatic drive_input();
    int idx;
    idx = 0;
    while (idx < in_beats.size()) begin
      @(posedge aclk);
      if (i_s_valid && o_s_ready) begin
        if (idx == pkt_end[pkts_in]) pkts_in++;
        idx++;
      end
      if (idx == in_beats.size()) begin
        i_s_valid <= 1'b0;
      end else if (!(i_s_valid && !o_s_ready)) begin
        rng_src = xorshift32(rng_src);
        i_s_valid <= (rng_src[1:0] != 2'b00);
        i_s_data  <= in_beats[idx];
      end
    end
  endtask

  // Output held off until two packets are in, then random back-pressure
  task automatic drain_output();
    wait (pkts_in >= 2);
    repeat (STALL_CYCLES) @(posedge aclk);
    while (pkts_out < NUM_PKTS) begin
      @(posedge aclk);
      if (o_m_valid && i_m_ready && o_m_last) pkts_out++;
      rng_snk = xorshift32(rng_snk);
      i_m_ready <= (rng_snk[1:0] != 2'b00);
    end
    i_m_ready <= 1'b0;
  endtask

  // ==================================================
  // Main sequence
  // ==================================================
  initial begin
    int total;
    i_rst_n   = 1'b0;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_m_ready = 1'b0;
    pkts_in   = 0;
    pkts_out  = 0;
    wd_limit  = 0;
    rng_src   = 32'hbd65_6dfe;
    build_packets(total);
    rng_snk  = ~rng_src;
    wd_limit = (longint'(total) * 4 + 16 + STALL_CYCLES + 200) * 8;
    repeat (16) @(posedge aclk);
    i_rst_n <= 1'b1;
    fork
      drive_input();
      drain_output();
    join
    repeat (2) @(posedge aclk);
    if (UUT.u_asserts.fail_cnt == 0) begin
      $display("Done: no errors");
      $finish;
    end else begin
      $display("Done: errors found");
      $fatal(1, "Assertion failures were recorded");
    end
  end

  initial begin
    wait (UUT.u_asserts.fail_cnt != 0);
    $display("** Error (%0t): %s", $time, UUT.u_asserts.fail_msg);
    $display("Done: errors found");
    $fatal(1, "Stopped at the first failed assertion");
  end

  // Watchdog
  initial begin
    wait (wd_limit != 0);
    #(wd_limit);
    $display("Timeout: the packets were not replayed within %0d time units", wd_limit);
    $display("Done: errors found");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== all.f ====
+incdir+.
wr_pkg.sv
wr_loader.sv
wr_bank_pair.sv
wr_reader.sv
weight_rotator.sv
weight_rotator_asserts.sv
tb_weight_rotator.sv

// ==== Bender.yml ====
package:
  name: weight_rotator

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - wr_pkg.sv
      - wr_loader.sv
      - wr_bank_pair.sv
      - wr_reader.sv
      - weight_rotator.sv
  - target: test
    include_dirs:
      - .
    files:
      - weight_rotator_asserts.sv
      - tb_weight_rotator.sv
